// ==== Makefile ====
# Verilator build and run for the serial bus switch testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module core_logic_tb \
		-Mdir obj_dir -o core_logic_sim

run: compile
	./obj_dir/core_logic_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/bus_route_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_logic_defines.svh"

module bus_route_exec import core_logic_pkg::*; (
  input  logic                   mcu_nss,
  input  logic                   mcu_sck,
  spi_cmd_if.exec                cmd,
  input  logic                   cop_cs_n,
  input  logic                   cop_sclk,
  input  logic                   cop_mosi,
  input  logic                   host_cs_n,
  input  logic                   host_sclk,
  input  logic                   host_mosi,
  output logic                   ram_cs_n,
  output logic                   ram_sclk,
  output logic                   ram_mosi,
  output bus_mode_e              bus_mode,
  output logic [`BYTE_WIDTH-1:0] status_byte
);

  localparam int FRAME_CNT_WIDTH = 4;

  logic [FRAME_CNT_WIDTH-1:0] ram_frames;
  logic                       cop_cs_q;
  logic                       cop_cs_qq;
  logic                       host_route;
  logic                       cop_route;
  logic                       host_ram_end;
  logic                       cop_ram_end;

  // Coprocessor select is only watched for the end of its frames
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      cop_cs_q  <= 1'b1;
      cop_cs_qq <= 1'b1;
    end else begin
      cop_cs_q  <= cop_cs_n;
      cop_cs_qq <= cop_cs_q;
    end
  end

  // Host gets the RAM only for the payload of an access frame
  assign host_route = (bus_mode == BUS_HOST) && (cmd.state == ACCESS_RAM);
  assign cop_route  = (bus_mode == BUS_COP);

  // A RAM frame counts only if it actually reached the RAM pins
  assign host_ram_end = cmd.frame_end && (cmd.frame_op == OP_ACCESS_RAM) &&
                        (bus_mode == BUS_HOST);
  assign cop_ram_end  = cop_cs_q && !cop_cs_qq && cop_route;

  // Ownership only changes between host frames
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      bus_mode <= BUS_HOST;
    end else if (cmd.frame_end) begin
      if (cmd.frame_op == OP_GRANT_COP) begin
        bus_mode <= BUS_COP;
      end else if (cmd.frame_op == OP_RESET_BUS) begin
        bus_mode <= BUS_HOST;
      end
    end
  end

  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      ram_frames <= '0;
    end else if (host_ram_end || cop_ram_end) begin
      ram_frames <= ram_frames + 1'b1;
    end
  end

  // Owner in the top bit and frame count in the low nibble
  assign status_byte = {bus_mode == BUS_COP,
                        {(`BYTE_WIDTH - 1 - FRAME_CNT_WIDTH){1'b0}},
                        ram_frames};

  // Pass-through has no clock latency because the pins drive the RAM directly
  always_comb begin
    if (host_route) begin
      ram_cs_n = host_cs_n;
      ram_sclk = host_sclk;
      ram_mosi = host_mosi;
    end else if (cop_route) begin
      ram_cs_n = cop_cs_n;
      ram_sclk = cop_sclk;
      ram_mosi = cop_mosi;
    end else begin
      // Idle RAM bus
      ram_cs_n = 1'b1;
      ram_sclk = 1'b0;
      ram_mosi = 1'b0;
    end
  end

  // Both masters must never be connected to the RAM at once
  a_single_route : assert property (@(posedge mcu_nss) disable iff (!mcu_sck)
    !(host_route && cop_route))
    else $error("host and coprocessor routed to RAM together");

endmodule

`default_nettype wire

// ==== hdl/core_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_logic_defines.svh"

module core_logic import core_logic_pkg::*; (
  input  logic mcu_nss,
  input  logic mcu_sck,
  // Host port, the switch is the slave
  input  logic host_cs_n,
  input  logic host_sclk,
  input  logic host_mosi,
  output logic host_miso,
  // Coprocessor port, the switch is the slave
  input  logic cop_cs_n,
  input  logic cop_sclk,
  input  logic cop_mosi,
  output logic cop_miso,
  // Serial RAM port, the switch is the master
  output logic ram_cs_n,
  output logic ram_sclk,
  output logic ram_mosi,
  input  logic ram_miso
);

  bus_mode_e              bus_mode;
  logic [`BYTE_WIDTH-1:0] status_byte;

  spi_cmd_if i_cmd ();

  spi_cmd_decode i_decode (
    .mcu_nss   (mcu_nss),
    .mcu_sck   (mcu_sck),
    .host_cs_n (host_cs_n),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .cmd       (i_cmd.decode)
  );

  bus_route_exec i_exec (
    .mcu_nss     (mcu_nss),
    .mcu_sck     (mcu_sck),
    .cmd         (i_cmd.exec),
    .cop_cs_n    (cop_cs_n),
    .cop_sclk    (cop_sclk),
    .cop_mosi    (cop_mosi),
    .host_cs_n   (host_cs_n),
    .host_sclk   (host_sclk),
    .host_mosi   (host_mosi),
    .ram_cs_n    (ram_cs_n),
    .ram_sclk    (ram_sclk),
    .ram_mosi    (ram_mosi),
    .bus_mode    (bus_mode),
    .status_byte (status_byte)
  );

  miso_result i_result (
    .mcu_nss     (mcu_nss),
    .mcu_sck     (mcu_sck),
    .cmd         (i_cmd.result),
    .bus_mode    (bus_mode),
    .status_byte (status_byte),
    .ram_miso    (ram_miso),
    .host_sclk   (host_sclk),
    .host_miso   (host_miso),
    .cop_miso    (cop_miso)
  );

endmodule

`default_nettype wire

// ==== hdl/core_logic_pkg.sv ====
`default_nettype none

`include "core_logic_defines.svh"

package core_logic_pkg;

  // Host opcodes, with the same encoding as the opcode byte
  typedef enum logic [2:0] {
    OP_NOP         = 3'(`OP_NOP),
    OP_READ_STATUS = 3'(`OP_READ_STATUS),
    OP_ACCESS_RAM  = 3'(`OP_ACCESS_RAM),
    OP_GRANT_COP   = 3'(`OP_GRANT_COP),
    OP_RESET_BUS   = 3'(`OP_RESET_BUS)
  } host_op_e;

  // Host frame state
  // IDLE while select is high, OPCODE for the first byte, then one of the
  // three data states for the remainder of the frame
  typedef enum logic [2:0] {
    IDLE,
    OPCODE,
    READ_STATUS,
    ACCESS_RAM,
    NOP_DATA
  } host_state_e;

  // Which master currently owns the serial RAM
  typedef enum logic {
    BUS_HOST = 1'b0,
    BUS_COP  = 1'b1
  } bus_mode_e;

endpackage

`default_nettype wire

// ==== hdl/miso_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_logic_defines.svh"

module miso_result import core_logic_pkg::*; (
  input  logic                   mcu_nss,
  input  logic                   mcu_sck,
  spi_cmd_if.result              cmd,
  input  bus_mode_e              bus_mode,
  input  logic [`BYTE_WIDTH-1:0] status_byte,
  input  logic                   ram_miso,
  input  logic                   host_sclk,
  output logic                   host_miso,
  output logic                   cop_miso
);

  logic                   sclk_q;
  logic                   sclk_qq;
  logic                   sclk_fall;
  logic [`BYTE_WIDTH-1:0] status_q;

  // Own sampled copy of the host clock for falling edge detection
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      sclk_q  <= 1'b0;
      sclk_qq <= 1'b0;
    end else begin
      sclk_q  <= host_sclk;
      sclk_qq <= sclk_q;
    end
  end

  assign sclk_fall = ~sclk_q & sclk_qq;

  // Freeze the status when the opcode is known, so a read sees one value
  always_ff @(posedge mcu_nss) begin
    if (cmd.op_done) begin
      status_q <= status_byte;
    end
  end

  // Host output changes only on falling edges and is stable by the next rise
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      host_miso <= 1'b0;
    end else if (sclk_fall) begin
      if (cmd.state == READ_STATUS) begin
        host_miso <= status_q[cmd.bit_index];
      end else if (cmd.state == ACCESS_RAM && bus_mode == BUS_HOST) begin
        host_miso <= ram_miso;
      end else begin
        // Echo of the previous byte, LSB first
        host_miso <= cmd.echo_bit;
      end
    end
  end

  // RAM reply goes straight back to the coprocessor while it owns the bus
  assign cop_miso = (bus_mode == BUS_COP) & ram_miso;

endmodule

`default_nettype wire

// ==== hdl/spi_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_logic_defines.svh"

module spi_cmd_decode import core_logic_pkg::*; (
  input  logic      mcu_nss,
  input  logic      mcu_sck,
  input  logic      host_cs_n,
  input  logic      host_sclk,
  input  logic      host_mosi,
  spi_cmd_if.decode cmd
);

  localparam logic [`BIT_INDEX_WIDTH-1:0] LAST_BIT = `BIT_INDEX_WIDTH'(`BYTE_WIDTH - 1);

  logic                        cs_q;
  logic                        sclk_q;
  logic                        sclk_qq;
  logic                        mosi_q;
  logic                        sclk_rise;
  logic                        byte_done;
  logic [`BYTE_WIDTH-1:0]      shift_q;
  logic [`BIT_INDEX_WIDTH-1:0] bit_cnt;
  host_state_e                 state_q;
  host_op_e                    op_q;
  host_op_e                    next_op;
  logic                        op_done_q;
  logic                        frame_end_q;

  // Map a received opcode byte onto the opcode enum
  function automatic host_op_e decode_op(input logic [`BYTE_WIDTH-1:0] b);
    host_op_e op;
    case (b)
      `BYTE_WIDTH'(`OP_NOP):         op = OP_NOP;
      `BYTE_WIDTH'(`OP_READ_STATUS): op = OP_READ_STATUS;
      `BYTE_WIDTH'(`OP_ACCESS_RAM):  op = OP_ACCESS_RAM;
      `BYTE_WIDTH'(`OP_GRANT_COP):   op = OP_GRANT_COP;
      `BYTE_WIDTH'(`OP_RESET_BUS):   op = OP_RESET_BUS;
      default:                       op = OP_NOP;
    endcase
    return op;
  endfunction

  // Only status reads and RAM access have their own data phase
  function automatic host_state_e op_state(input host_op_e op);
    host_state_e st;
    case (op)
      OP_READ_STATUS: st = READ_STATUS;
      OP_ACCESS_RAM:  st = ACCESS_RAM;
      default:        st = NOP_DATA;
    endcase
    return st;
  endfunction

  // Sample the host lines once per clock, edges come from these copies
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      cs_q    <= 1'b1;
      sclk_q  <= 1'b0;
      sclk_qq <= 1'b0;
      mosi_q  <= 1'b0;
    end else begin
      cs_q    <= host_cs_n;
      sclk_q  <= host_sclk;
      sclk_qq <= sclk_q;
      mosi_q  <= host_mosi;
    end
  end

  assign sclk_rise = sclk_q & ~sclk_qq;
  assign next_op   = decode_op(shift_q);

  // LSB arrives first, so new bits enter at the top and move down
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      shift_q <= '0;
    end else if (sclk_rise && !cs_q) begin
      shift_q <= {mosi_q, shift_q[`BYTE_WIDTH-1:1]};
    end
  end

  // Frame FSM with the bit counter and the two strobes
  always_ff @(posedge mcu_nss or negedge mcu_sck) begin
    if (!mcu_sck) begin
      state_q     <= IDLE;
      bit_cnt     <= '0;
      byte_done   <= 1'b0;
      op_q        <= OP_NOP;
      op_done_q   <= 1'b0;
      frame_end_q <= 1'b0;
    end else begin
      op_done_q   <= 1'b0;
      frame_end_q <= 1'b0;
      byte_done   <= 1'b0;
      if (cs_q) begin
        // Select released, close the frame once
        bit_cnt <= '0;
        if (state_q != IDLE) begin
          state_q     <= IDLE;
          frame_end_q <= 1'b1;
        end
      end else begin
        if (state_q == IDLE) begin
          // A frame that ends before its opcode byte counts as a NOP
          state_q <= OPCODE;
          op_q    <= OP_NOP;
        end else if (state_q == OPCODE && byte_done) begin
          state_q   <= op_state(next_op);
          op_q      <= next_op;
          op_done_q <= 1'b1;
        end
        if (sclk_rise) begin
          // Counter wraps by itself at the end of each byte
          bit_cnt   <= bit_cnt + 1'b1;
          byte_done <= (bit_cnt == LAST_BIT);
        end
      end
    end
  end

  assign cmd.state     = state_q;
  assign cmd.bit_index = bit_cnt;
  assign cmd.echo_bit  = shift_q[0];
  assign cmd.op_done   = op_done_q;
  assign cmd.frame_op  = op_q;
  assign cmd.frame_end = frame_end_q;

  // The opcode strobe never lasts beyond one clock
  a_op_done_pulse : assert property (@(posedge mcu_nss) disable iff (!mcu_sck)
    op_done_q |=> !op_done_q)
    else $error("op_done held for more than one clock");

  // A released select always brings the FSM back to IDLE on the next clock
  a_idle_on_release : assert property (@(posedge mcu_nss) disable iff (!mcu_sck)
    cs_q |=> state_q == IDLE)
    else $error("frame state not IDLE after select release");

endmodule

`default_nettype wire

// ==== hdl/spi_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_logic_defines.svh"

interface spi_cmd_if import core_logic_pkg::*; ();

  // Decoded view of the current host frame
  host_state_e                 state;
  logic [`BIT_INDEX_WIDTH-1:0] bit_index;
  // Oldest bit in the host shift register, used to echo the last byte
  logic                        echo_bit;
  logic                        op_done;
  // Opcode of the frame, valid until the frame_end pulse
  host_op_e                    frame_op;
  logic                        frame_end;

  modport decode (output state, bit_index, echo_bit, op_done, frame_op, frame_end);

  // The router only needs the frame state and the end-of-frame information
  modport exec (input state, frame_op, frame_end);

  // The output mux needs the bit position, the echo bit and the opcode strobe
  modport result (input state, bit_index, echo_bit, op_done);

endinterface

`default_nettype wire

// ==== include/core_logic_defines.svh ====
`ifndef CORE_LOGIC_DEFINES_SVH
`define CORE_LOGIC_DEFINES_SVH

// Bits carried by one serial byte on any of the three ports
`define BYTE_WIDTH 8

// Counts the bits of a byte, so it must hold BYTE_WIDTH - 1
`define BIT_INDEX_WIDTH 3

// Opcode byte values sent by the host as the first byte of a frame
// Any byte outside this set is treated as a NOP
`define OP_NOP 0
`define OP_READ_STATUS 1
`define OP_ACCESS_RAM 2
`define OP_GRANT_COP 3
`define OP_RESET_BUS 4

`endif

// ==== sim.f ====
+incdir+include
hdl/core_logic_pkg.sv
hdl/spi_cmd_if.sv
hdl/spi_cmd_decode.sv
hdl/bus_route_exec.sv
hdl/miso_result.sv
hdl/core_logic.sv
test/core_logic_checker.sv
test/core_logic_tb.sv

// ==== test/core_logic_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_logic_checker (
  input  logic       mcu_nss,
  input  logic       mcu_sck,
  input  logic       host_cs_n,
  input  logic       host_sclk,
  input  logic       host_miso,
  input  logic       cop_cs_n,
  input  logic       cop_sclk,
  input  logic       cop_miso,
  input  logic       ram_cs_n,
  input  logic       ram_sclk,
  input  logic       ram_mosi,
  // Expected values of the frame in flight, set by the testbench before select falls
  input  logic       exp_port,
  input  logic [7:0] exp_payload,
  input  logic [7:0] exp_byte,
  input  logic       exp_trail,
  input  logic [7:0] exp_trail_byte,
  input  logic       exp_ram_act,
  input  int         frame_num,
  output int         frames_checked,
  output int         frames_failed
);

  logic       host_cs_p;
  logic       host_sclk_p;
  logic       cop_cs_p;
  logic       cop_sclk_p;
  logic       ram_cs_p;
  logic       ram_sclk_p;
  logic [5:0] host_cnt;
  logic [7:0] host_b1;
  logic [7:0] host_b2;
  logic [3:0] cop_cnt;
  logic [7:0] cop_b;
  logic [3:0] ram_cnt;
  logic [7:0] ram_b;
  logic       ram_low;
  bit         frame_bad;

  // Compare one collected byte and report a mismatch in hex
  task automatic check_byte(input string sig, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error %s: got 8'h%02h, expected 8'h%02h (frame %0d)", sig, got, exp, frame_num);
      frame_bad = 1'b1;
    end
  endtask

  // Judge the frame that has just ended and print its result line
  task automatic finish_frame();
    int host_edges;
    frame_bad  = 1'b0;
    host_edges = exp_trail ? 24 : 16;
    if (!exp_port) begin
      if (host_cnt != 6'(host_edges)) begin
        $display("frame %0d: host clocked %0d bits instead of %0d",
                 frame_num, host_cnt, host_edges);
        frame_bad = 1'b1;
      end
      check_byte("host_miso", host_b1, exp_byte);
      // Third byte of a data-less frame must echo the payload
      if (exp_trail) begin
        check_byte("host_miso", host_b2, exp_trail_byte);
      end
    end else begin
      if (cop_cnt != 4'd8) begin
        $display("frame %0d: coprocessor clocked %0d bits instead of 8", frame_num, cop_cnt);
        frame_bad = 1'b1;
      end
      check_byte("cop_miso", cop_b, exp_byte);
    end
    if (exp_ram_act) begin
      if (!ram_low) begin
        $display("frame %0d: RAM select never went low", frame_num);
        frame_bad = 1'b1;
      end else if (ram_cnt != 4'd8) begin
        $display("frame %0d: RAM saw %0d clock edges instead of 8", frame_num, ram_cnt);
        frame_bad = 1'b1;
      end else begin
        check_byte("ram_mosi", ram_b, exp_payload);
      end
    end else if (ram_low) begin
      $display("frame %0d: RAM select went low although the RAM is not routed here",
               frame_num);
      frame_bad = 1'b1;
    end
    frames_checked = frames_checked + 1;
    if (frame_bad) begin
      frames_failed = frames_failed + 1;
      $display("frame %0d: FAILED", frame_num);
    end else begin
      $display("frame %0d: ok", frame_num);
    end
  endtask

  // All ports are sampled on the clock, so edges come from the previous sample
  always @(posedge mcu_nss) begin
    if (!mcu_sck) begin
      host_cs_p      = 1'b1;
      host_sclk_p    = 1'b0;
      cop_cs_p       = 1'b1;
      cop_sclk_p     = 1'b0;
      ram_cs_p       = 1'b1;
      ram_sclk_p     = 1'b0;
      host_cnt       = '0;
      cop_cnt        = '0;
      ram_cnt        = '0;
      ram_low        = 1'b0;
      frames_checked = 0;
      frames_failed  = 0;
    end else begin
      if ((host_cs_p && !host_cs_n) || (cop_cs_p && !cop_cs_n)) begin
        // A new frame starts on either port
        host_cnt = '0;
        cop_cnt  = '0;
        ram_cnt  = '0;
        ram_low  = 1'b0;
        host_b1  = '0;
        host_b2  = '0;
        cop_b    = '0;
        ram_b    = '0;
      end else begin
        // Byte 0 of a host frame is the opcode, its miso bits are not checked
        if (!host_cs_p && !host_cs_n && !host_sclk_p && host_sclk) begin
          if (host_cnt[5:3] == 3'd1)
            host_b1[host_cnt[2:0]] = host_miso;
          else if (host_cnt[5:3] == 3'd2)
            host_b2[host_cnt[2:0]] = host_miso;
          host_cnt = host_cnt + 1'b1;
        end
        if (!cop_cs_p && !cop_cs_n && !cop_sclk_p && cop_sclk) begin
          if (cop_cnt < 4'd8)
            cop_b[cop_cnt[2:0]] = cop_miso;
          cop_cnt = cop_cnt + 1'b1;
        end
        if (!ram_cs_n) begin
          ram_low = 1'b1;
        end
        // An sclk rise that comes together with the select fall is not a data edge
        if (!ram_cs_p && !ram_cs_n && !ram_sclk_p && ram_sclk) begin
          if (ram_cnt < 4'd8)
            ram_b[ram_cnt[2:0]] = ram_mosi;
          ram_cnt = ram_cnt + 1'b1;
        end
      end
      if (!host_cs_p && host_cs_n && !exp_port) begin
        finish_frame();
      end
      if (!cop_cs_p && cop_cs_n && exp_port) begin
        finish_frame();
      end
      host_cs_p   = host_cs_n;
      host_sclk_p = host_sclk;
      cop_cs_p    = cop_cs_n;
      cop_sclk_p  = cop_sclk;
      ram_cs_p    = ram_cs_n;
      ram_sclk_p  = ram_sclk;
    end
  end

endmodule

`default_nettype wire

// ==== test/core_logic_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_logic_tb;

  localparam int MAX_FRAMES = 32;
  localparam int FIELDS     = 6;
  // Three bytes of eight bits at eight clocks each, plus select and gap time
  localparam int FRAME_CLKS = 240;
  localparam int MARGIN     = 200;

  logic       mcu_nss;
  logic       mcu_sck;
  logic       host_cs_n;
  logic       host_sclk;
  logic       host_mosi;
  logic       host_miso;
  logic       cop_cs_n;
  logic       cop_sclk;
  logic       cop_mosi;
  logic       cop_miso;
  logic       ram_cs_n;
  logic       ram_sclk;
  logic       ram_mosi;
  logic       ram_miso;

  logic       exp_port;
  logic [7:0] exp_payload;
  logic [7:0] exp_byte;
  logic       exp_trail;
  logic [7:0] exp_trail_byte;
  logic       exp_ram_act;
  int         frame_num;
  int         frames_checked;
  int         frames_failed;

  logic [7:0]  vec_mem [0:MAX_FRAMES*FIELDS-1];
  int          num_frames;
  int unsigned cycle_count;
  int unsigned cycle_limit = 32'hffff_ffff;

  // RAM model state
  logic [7:0] ram_reply;
  logic       ram_cs_p;
  logic       ram_sclk_p;
  logic [3:0] ram_rises;

  core_logic i_core_logic (
    .mcu_nss   (mcu_nss),
    .mcu_sck   (mcu_sck),
    .host_cs_n (host_cs_n),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_miso (host_miso),
    .cop_cs_n  (cop_cs_n),
    .cop_sclk  (cop_sclk),
    .cop_mosi  (cop_mosi),
    .cop_miso  (cop_miso),
    .ram_cs_n  (ram_cs_n),
    .ram_sclk  (ram_sclk),
    .ram_mosi  (ram_mosi),
    .ram_miso  (ram_miso)
  );

  core_logic_checker i_checker (
    .mcu_nss        (mcu_nss),
    .mcu_sck        (mcu_sck),
    .host_cs_n      (host_cs_n),
    .host_sclk      (host_sclk),
    .host_miso      (host_miso),
    .cop_cs_n       (cop_cs_n),
    .cop_sclk       (cop_sclk),
    .cop_miso       (cop_miso),
    .ram_cs_n       (ram_cs_n),
    .ram_sclk       (ram_sclk),
    .ram_mosi       (ram_mosi),
    .exp_port       (exp_port),
    .exp_payload    (exp_payload),
    .exp_byte       (exp_byte),
    .exp_trail      (exp_trail),
    .exp_trail_byte (exp_trail_byte),
    .exp_ram_act    (exp_ram_act),
    .frame_num      (frame_num),
    .frames_checked (frames_checked),
    .frames_failed  (frames_failed)
  );

  initial begin
    mcu_nss = 1'b0;
    forever #2 mcu_nss = ~mcu_nss;
  end

  // Serial RAM in SPI mode 0: first bit at select fall, next bit after each fall
  always @(posedge mcu_nss) begin
    if (!mcu_sck) begin
      ram_rises  <= '0;
      ram_cs_p   <= 1'b1;
      ram_sclk_p <= 1'b0;
    end else begin
      if (ram_cs_p && !ram_cs_n) begin
        ram_rises <= '0;
        ram_miso  <= ram_reply[0];
      end else if (!ram_cs_p && !ram_cs_n) begin
        if (!ram_sclk_p && ram_sclk) begin
          ram_rises <= ram_rises + 1'b1;
        end else if (ram_sclk_p && !ram_sclk && ram_rises != 0 && ram_rises < 4'd8) begin
          ram_miso <= ram_reply[ram_rises[2:0]];
        end
      end
      ram_cs_p   <= ram_cs_n;
      ram_sclk_p <= ram_sclk;
    end
  end

  // Run limit, worked out from the number of frames once the vectors are read
  always @(posedge mcu_nss) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run exceeded %0d clocks", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // One byte LSB first; mosi moves while sclk is low, each level lasts 4 clocks
  task automatic shift_byte(input logic port, input logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++) begin
      @(posedge mcu_nss);
      if (port) cop_mosi <= b[i];
      else host_mosi <= b[i];
      repeat (3) @(posedge mcu_nss);
      if (port) cop_sclk <= 1'b1;
      else host_sclk <= 1'b1;
      repeat (4) @(posedge mcu_nss);
      if (port) cop_sclk <= 1'b0;
      else host_sclk <= 1'b0;
    end
  endtask

  task automatic run_frame(input int idx);
    logic [7:0] port_f;
    logic [7:0] op;
    logic [7:0] payload;
    logic [7:0] reply;
    logic [7:0] expect_b;
    logic [7:0] ram_f;
    logic [7:0] trail;
    logic       echo;
    port_f   = vec_mem[idx*FIELDS];
    op       = vec_mem[idx*FIELDS+1];
    payload  = vec_mem[idx*FIELDS+2];
    reply    = vec_mem[idx*FIELDS+3];
    expect_b = vec_mem[idx*FIELDS+4];
    ram_f    = vec_mem[idx*FIELDS+5];
    // Frames without a data phase of their own get a random third byte
    echo  = (port_f == 8'h00) && (op != 8'h01) && (op != 8'h02);
    trail = 8'($urandom);
    @(posedge mcu_nss);
    exp_port       <= port_f[0];
    exp_payload    <= payload;
    exp_byte       <= expect_b;
    exp_trail      <= echo;
    exp_trail_byte <= payload;
    exp_ram_act    <= ram_f[0];
    frame_num      <= idx;
    ram_reply      <= reply;
    @(posedge mcu_nss);
    if (port_f[0]) cop_cs_n <= 1'b0;
    else host_cs_n <= 1'b0;
    repeat (4) @(posedge mcu_nss);
    if (port_f[0]) begin
      shift_byte(1'b1, payload);
    end else begin
      shift_byte(1'b0, op);
      shift_byte(1'b0, payload);
      if (echo) shift_byte(1'b0, trail);
    end
    repeat (4) @(posedge mcu_nss);
    if (port_f[0]) cop_cs_n <= 1'b1;
    else host_cs_n <= 1'b1;
    // Leave room for frame_end and the owner and counter updates
    repeat (10) @(posedge mcu_nss);
  endtask

  initial begin
    int seed_val;
    int f;
    mcu_sck        = 1'b0;
    host_cs_n      = 1'b1;
    host_sclk      = 1'b0;
    host_mosi      = 1'b0;
    cop_cs_n       = 1'b1;
    cop_sclk       = 1'b0;
    cop_mosi       = 1'b0;
    ram_miso       = 1'b0;
    ram_reply      = 8'h00;
    exp_port       = 1'b0;
    exp_payload    = 8'h00;
    exp_byte       = 8'h00;
    exp_trail      = 1'b0;
    exp_trail_byte = 8'h00;
    exp_ram_act    = 1'b0;
    frame_num      = 0;
    cycle_count    = 0;
    seed_val       = $urandom(32'h8391);
    $readmemh("test/core_logic_vectors.txt", vec_mem);
    // The list ends at a line whose port field is ff
    num_frames = 0;
    while (num_frames < MAX_FRAMES && vec_mem[num_frames*FIELDS] != 8'hff) begin
      num_frames = num_frames + 1;
    end
    cycle_limit = num_frames * FRAME_CLKS + MARGIN;
    repeat (3) @(posedge mcu_nss);
    mcu_sck <= 1'b1;
    repeat (2) @(posedge mcu_nss);
    for (f = 0; f < num_frames; f++) begin
      run_frame(f);
    end
    repeat (4) @(posedge mcu_nss);
    $display("%0d of %0d frames checked, %0d failed", frames_checked, num_frames, frames_failed);
    if (frames_failed == 0 && frames_checked == num_frames && num_frames > 0) begin
      $display("All tests passed");
    end else begin
      if (frames_checked != num_frames)
        $display("not every frame reached the checker");
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/core_logic_vectors.txt ====
// port(0 host, 1 cop) opcode payload ram_reply expected_miso_byte ram_routed
// Expected byte is host_miso during the payload, or cop_miso for a cop frame
00 01 ff 00 00 00
00 02 a5 3c 3c 01
00 01 00 00 01 00
00 00 5a 00 00 00
00 03 11 00 03 00
00 01 00 00 81 00
01 00 c3 96 96 01
00 02 77 e1 02 00
00 01 00 00 82 00
00 04 22 00 04 00
00 01 00 00 02 00
01 00 3c ff 00 00
00 01 00 00 02 00
00 02 0f 81 81 01
00 01 00 00 03 00
00 7e 44 00 7e 00
// End of list
ff ff ff ff ff ff
